//--- platform_base.sv
/*
 * Platform base
 * Joins the SPI ROM loader, stereo sigma-delta DACs and the video
 * output mux for the arcade core
 */
`timescale 1ns/10ps

module platform_base
    import platform_pkg::*;
(
    input  logic        clk_rom,
    input  logic        rst_n,
    // Native core video
    input  color4_t     game_r,
    input  color4_t     game_g,
    input  color4_t     game_b,
    input  logic        hs,
    input  logic        vs,
    // Scan doubler video
    input  color6_t     scan2x_r,
    input  color6_t     scan2x_g,
    input  color6_t     scan2x_b,
    input  logic        scan2x_hs,
    input  logic        scan2x_vs,
    input  logic [3:0]  vgactrl_en,
    // Sound
    input  snd_sample_t snd_left,
    input  snd_sample_t snd_right,
    output logic        snd_pwm_l,
    output logic        snd_pwm_r,
    // Final video
    output color6_t     video_r,
    output color6_t     video_g,
    output color6_t     video_b,
    output logic        video_hs,
    output logic        video_vs,
    output logic        scan2x_enb,   // High turns the doubler off
    output logic [31:0] status,
    // Serial flash
    output logic        sd_cs_n,
    output logic        sd_clk,
    output logic        sd_mosi,
    input  logic        sd_miso,
    // ROM download
    output rom_addr_t   ioctl_addr,
    output spi_byte_t   ioctl_data,
    output logic        ioctl_wr,
    output logic        downloading
);

    // Control word mapping
    assign scan2x_enb = vgactrl_en[0];
    assign status     = {26'd0, vgactrl_en[3:1], 3'd0};

    spi_rom_loader u_loader (
        .clk_rom     (clk_rom),
        .rst_n       (rst_n),
        .sd_cs_n     (sd_cs_n),
        .sd_clk      (sd_clk),
        .sd_mosi     (sd_mosi),
        .sd_miso     (sd_miso),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .downloading (downloading)
    );

    sigma_delta_dac dac_l (
        .clk_rom (clk_rom),
        .rst_n   (rst_n),
        .sample  (snd_left),
        .pwm     (snd_pwm_l)
    );

    sigma_delta_dac dac_r (
        .clk_rom (clk_rom),
        .rst_n   (rst_n),
        .sample  (snd_right),
        .pwm     (snd_pwm_r)
    );

    video_out_mux u_video (
        .scan2x_enb (scan2x_enb),
        .game_r     (game_r),
        .game_g     (game_g),
        .game_b     (game_b),
        .hs         (hs),
        .vs         (vs),
        .scan2x_r   (scan2x_r),
        .scan2x_g   (scan2x_g),
        .scan2x_b   (scan2x_b),
        .scan2x_hs  (scan2x_hs),
        .scan2x_vs  (scan2x_vs),
        .video_r    (video_r),
        .video_g    (video_g),
        .video_b    (video_b),
        .video_hs   (video_hs),
        .video_vs   (video_vs)
    );

endmodule

//--- platform_cfg.svh
/*
 * Platform base configuration
 * Build-time constants for the SPI ROM loader and the audio DACs
 */
`ifndef PLATFORM_CFG_SVH
`define PLATFORM_CFG_SVH

// SPI clock divider
`define SPI_HALF_DIV 2          // clk_rom cycles per half SCK period, keep >= 2

// ROM download
`define ROM_BYTES    64         // Bytes streamed into the core
`define ROM_BASE     24'h010000 // Flash start address of the image

// Audio
`define DAC_WIDTH    16         // Sample width in bits

`endif

//--- platform_pkg.sv
/*
 * Platform base types
 * Vector types shared by the loader, the video path and the DACs
 */
`include "platform_cfg.svh"

package platform_pkg;

    // Signed audio sample from the game core
    typedef logic signed [`DAC_WIDTH-1:0] snd_sample_t;

    // Native core colour, one component
    typedef logic [3:0] color4_t;

    // Output colour after padding or doubling
    typedef logic [5:0] color6_t;

    // Download address into the core's ROM space
    typedef logic [21:0] rom_addr_t;

    // One SPI transfer
    typedef logic [7:0] spi_byte_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the platform base testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sources.f --top-module tb_platform_base
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_platform_base > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
exit 1

//--- sigma_delta_dac.sv
/*
 * Sigma-delta DAC
 * First-order modulator, signed sample in, one-bit PWM stream out
 */
`timescale 1ns/10ps
`include "platform_cfg.svh"

module sigma_delta_dac
    import platform_pkg::*;
(
    input  logic        clk_rom,
    input  logic        rst_n,
    input  snd_sample_t sample,
    output logic        pwm
);

    localparam int W = `DAC_WIDTH;

    logic [W-1:0] ob_sample;    // Offset binary
    logic [W:0]   acc;          // Carry in the top bit

    // Flip the sign bit so silence sits at mid scale
    assign ob_sample = {~sample[W-1], sample[W-2:0]};

    // Residue feeds back, carry is the pulse
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[W-1:0]} + {1'b0, ob_sample};
        end
    end

    assign pwm = acc[W];        // One cycle behind the sample

endmodule

//--- sources.f
+incdir+.
platform_pkg.sv
spi_byte_engine.sv
spi_rom_loader.sv
sigma_delta_dac.sv
video_out_mux.sv
platform_base.sv
tb_spi_flash.sv
tb_platform_base.sv

//--- spi_byte_engine.sv
/*
 * SPI byte engine
 * Mode-0 master, one byte out and one byte in per start strobe
 */
`timescale 1ns/10ps
`include "platform_cfg.svh"

module spi_byte_engine
    import platform_pkg::*;
(
    input  logic      clk_rom,
    input  logic      rst_n,
    input  logic      start,
    input  spi_byte_t tx_byte,
    output spi_byte_t rx_byte,
    output logic      done,
    output logic      busy,
    output logic      sd_clk,
    output logic      sd_mosi,
    input  logic      sd_miso
);

    localparam int DIV_W = (`SPI_HALF_DIV > 2) ? $clog2(`SPI_HALF_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_HALF_DIV - 1);

    logic [DIV_W-1:0] div_cnt;  // Half period timer
    logic [2:0]       bit_cnt;  // Bits finished so far
    spi_byte_t        tx_sr;    // Outgoing bits, MSB on the wire
    spi_byte_t        rx_sr;    // Incoming bits
    logic             sclk;

    assign sd_clk  = sclk;
    assign sd_mosi = tx_sr[7];  // First bit already set up at start
    assign rx_byte = rx_sr;

    // The divider preloads to 1 so that the eighth falling edge lands
    // one cycle early and done shows up exactly 16 half periods after start
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            tx_sr   <= '0;
            rx_sr   <= '0;
            sclk    <= 1'b0;    // Idle low, mode 0
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;       // Single cycle strobe
            if (start && !busy) begin
                busy    <= 1'b1;
                tx_sr   <= tx_byte;
                div_cnt <= DIV_W'(1);
                bit_cnt <= '0;
                sclk    <= 1'b0;
            end else if (busy) begin
                if (div_cnt == DIV_LAST) begin
                    div_cnt <= '0;
                    sclk    <= ~sclk;
                    if (!sclk) begin
                        rx_sr <= {rx_sr[6:0], sd_miso};  // Rising edge, sample
                    end else begin
                        // Falling edge, next bit out
                        tx_sr   <= {tx_sr[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            busy <= 1'b0;
                            done <= 1'b1;  // rx_sr complete since last rise
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + DIV_W'(1);
                end
            end
        end
    end

endmodule

//--- spi_rom_loader.sv
/*
 * SPI ROM loader
 * Sends one flash read command after reset, then streams the image
 * into the core as ioctl write strobes
 */
`timescale 1ns/10ps
`include "platform_cfg.svh"

module spi_rom_loader
    import platform_pkg::*;
(
    input  logic      clk_rom,
    input  logic      rst_n,
    output logic      sd_cs_n,
    output logic      sd_clk,
    output logic      sd_mosi,
    input  logic      sd_miso,
    output rom_addr_t ioctl_addr,
    output spi_byte_t ioctl_data,
    output logic      ioctl_wr,
    output logic      downloading
);

    localparam spi_byte_t   RD_OPCODE = 8'h03;  // Plain flash read
    localparam logic [23:0] BASE      = `ROM_BASE;
    localparam rom_addr_t   LAST_ADDR = rom_addr_t'(`ROM_BYTES - 1);

    typedef enum logic [1:0] {
        PH_CMD,
        PH_ADDR,
        PH_DATA,
        PH_FIN
    } phase_t;

    phase_t    phase;
    rom_addr_t byte_cnt;    // Address byte index, then data byte index
    logic      eng_start;
    spi_byte_t eng_tx;
    spi_byte_t eng_rx;
    logic      eng_done;
    logic      eng_busy;
    spi_byte_t addr_byte;

    // Start address goes out MSB first
    always_comb begin
        case (byte_cnt[1:0])
            2'd0:    addr_byte = BASE[23:16];
            2'd1:    addr_byte = BASE[15:8];
            default: addr_byte = BASE[7:0];
        endcase
    end

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_CMD;
            byte_cnt    <= '0;
            sd_cs_n     <= 1'b1;
            eng_start   <= 1'b0;
            eng_tx      <= '0;
            ioctl_addr  <= '0;
            ioctl_data  <= '0;
            ioctl_wr    <= 1'b0;
            downloading <= 1'b1;    // Load begins straight after reset
        end else begin
            eng_start <= 1'b0;
            ioctl_wr  <= 1'b0;
            case (phase)
                PH_CMD: begin
                    if (sd_cs_n && !eng_busy) begin
                        sd_cs_n   <= 1'b0;       // Select and send opcode
                        eng_tx    <= RD_OPCODE;
                        eng_start <= 1'b1;
                    end else if (eng_done) begin
                        phase     <= PH_ADDR;
                        eng_tx    <= addr_byte;  // byte_cnt still 0 here
                        eng_start <= 1'b1;
                        byte_cnt  <= rom_addr_t'(1);
                    end
                end
                PH_ADDR: begin
                    if (eng_done) begin
                        eng_start <= 1'b1;
                        if (byte_cnt == rom_addr_t'(3)) begin
                            phase    <= PH_DATA;
                            eng_tx   <= 8'h00;   // Dummy byte clocks data in
                            byte_cnt <= '0;
                        end else begin
                            eng_tx   <= addr_byte;
                            byte_cnt <= byte_cnt + rom_addr_t'(1);
                        end
                    end
                end
                PH_DATA: begin
                    if (eng_done) begin
                        ioctl_wr   <= 1'b1;      // No back-pressure
                        ioctl_addr <= byte_cnt;
                        ioctl_data <= eng_rx;
                        if (byte_cnt == LAST_ADDR) begin
                            phase       <= PH_FIN;
                            sd_cs_n     <= 1'b1;
                            downloading <= 1'b0;
                        end else begin
                            eng_tx    <= 8'h00;
                            eng_start <= 1'b1;
                            byte_cnt  <= byte_cnt + rom_addr_t'(1);
                        end
                    end
                end
                default: ;                       // One load per reset
            endcase
        end
    end

    spi_byte_engine u_engine (
        .clk_rom (clk_rom),
        .rst_n   (rst_n),
        .start   (eng_start),
        .tx_byte (eng_tx),
        .rx_byte (eng_rx),
        .done    (eng_done),
        .busy    (eng_busy),
        .sd_clk  (sd_clk),
        .sd_mosi (sd_mosi),
        .sd_miso (sd_miso)
    );

endmodule

//--- tb_platform_base.sv
/*
 * Platform base testbench
 * Random video, audio and control stimulus checked against local
 * models, ROM load served by the SPI flash model
 */
`timescale 1ns/10ps
`include "platform_cfg.svh"

module tb_platform_base
    import platform_pkg::*;
();

    localparam int STROBE_TIMEOUT = 16 * `SPI_HALF_DIV * 8; // Command and first byte with margin
    localparam int CS_TIMEOUT     = 20;
    localparam int HALF           = 1 << (`DAC_WIDTH - 1);
    localparam int FULL           = 1 << `DAC_WIDTH;

    logic        clk_rom = 1'b0;
    logic        rst_n;
    color4_t     game_r;
    color4_t     game_g;
    color4_t     game_b;
    logic        hs;
    logic        vs;
    color6_t     scan2x_r;
    color6_t     scan2x_g;
    color6_t     scan2x_b;
    logic        scan2x_hs;
    logic        scan2x_vs;
    logic [3:0]  vgactrl_en;
    snd_sample_t snd_left;
    snd_sample_t snd_right;
    logic        snd_pwm_l;
    logic        snd_pwm_r;
    color6_t     video_r;
    color6_t     video_g;
    color6_t     video_b;
    logic        video_hs;
    logic        video_vs;
    logic        scan2x_enb;
    logic [31:0] status;
    logic        sd_cs_n;
    logic        sd_clk;
    logic        sd_mosi;
    logic        sd_miso;
    rom_addr_t   ioctl_addr;
    spi_byte_t   ioctl_data;
    logic        ioctl_wr;
    logic        downloading;
    int          cmd_count;
    int          flash_errs;

    logic [31:0] rng;
    int          mismatches = 0;
    int          problems = 0;
    int          res_l;             // Audio model residues
    int          res_r;
    logic        exp_pwm_l;
    logic        exp_pwm_r;

    platform_base i_dut (.*);

    tb_spi_flash i_flash (
        .sck       (sd_clk),
        .cs_n      (sd_cs_n),
        .mosi      (sd_mosi),
        .miso      (sd_miso),
        .cmd_count (cmd_count),
        .err_count (flash_errs)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %s", msg);
        problems++;
    endtask

    // Residue plus sample moved to offset binary
    function automatic int offset_sum(input int res, input snd_sample_t s);
        return res + int'(s) + HALF;
    endfunction

    initial begin
        forever #20 clk_rom = ~clk_rom;     // 25 MHz
    end

    // Audio reference, a pulse whenever the residue overflows
    always @(posedge clk_rom) begin
        if (!rst_n) begin
            res_l     <= 0;
            res_r     <= 0;
            exp_pwm_l <= 1'b0;
            exp_pwm_r <= 1'b0;
        end else begin
            res_l     <= offset_sum(res_l, snd_left) % FULL;
            res_r     <= offset_sum(res_r, snd_right) % FULL;
            exp_pwm_l <= offset_sum(res_l, snd_left) >= FULL;
            exp_pwm_r <= offset_sum(res_r, snd_right) >= FULL;
        end
    end

    // SCK idles while the flash is deselected
    always @(negedge clk_rom) begin
        if (sd_cs_n && sd_clk) begin
            report_problem("SD_CLK is high while SD_CS_N is high");
        end
    end

    task automatic watch_rom_load();
        int count;
        int waited;
        count = 0;
        while (count < `ROM_BYTES) begin
            waited = 0;
            @(negedge clk_rom);
            while (!ioctl_wr && waited < STROBE_TIMEOUT) begin
                @(negedge clk_rom);
                waited++;
            end
            if (!ioctl_wr) begin
                report_problem("timed out waiting for an ioctl_wr strobe");
                break;
            end
            check_value("ioctl_addr", 32'(ioctl_addr), 32'(count));
            check_value("ioctl_data", 32'(ioctl_data), 32'(i_flash.mem[8'(count)]));
            check_value("downloading", 32'(downloading), 32'(count != `ROM_BYTES - 1));
            count++;
        end
        waited = 0;
        while (!sd_cs_n && waited < CS_TIMEOUT) begin
            @(negedge clk_rom);
            waited++;
        end
        if (!sd_cs_n) begin
            report_problem("SD_CS_N stayed low after the last ROM byte");
        end
        for (int i = 0; i < 4 * STROBE_TIMEOUT; i++) begin
            @(negedge clk_rom);
            if (ioctl_wr) begin
                report_problem("extra ioctl_wr strobe after the last ROM byte");
            end
        end
    endtask

    task automatic video_sweep(input logic native);
        logic [31:0] r;
        for (int n = 0; n < 40; n++) begin
            @(posedge clk_rom);
            r = rand32();
            game_r    <= r[3:0];
            game_g    <= r[7:4];
            game_b    <= r[11:8];
            hs        <= r[12];
            vs        <= r[13];
            scan2x_r  <= r[19:14];
            scan2x_g  <= r[25:20];
            scan2x_b  <= r[31:26];
            r = rand32();
            scan2x_hs  <= r[0];
            scan2x_vs  <= r[1];
            vgactrl_en <= {r[4:2], native};
            @(negedge clk_rom);             // Mux settled, no clock involved
            if (native) begin
                check_value("video_r", 32'(video_r), 32'(game_r) * 4);
                check_value("video_g", 32'(video_g), 32'(game_g) * 4);
                check_value("video_b", 32'(video_b), 32'(game_b) * 4);
                check_value("video_hs", 32'(video_hs), 32'(hs == vs)); // Csync
                check_value("video_vs", 32'(video_vs), 32'd1);
            end else begin
                check_value("video_r", 32'(video_r), 32'(scan2x_r));
                check_value("video_g", 32'(video_g), 32'(scan2x_g));
                check_value("video_b", 32'(video_b), 32'(scan2x_b));
                check_value("video_hs", 32'(video_hs), 32'(scan2x_hs));
                check_value("video_vs", 32'(video_vs), 32'(scan2x_vs));
            end
            check_value("scan2x_enb", 32'(scan2x_enb), 32'(native));
            check_value("status", status, 32'(vgactrl_en[3:1]) << 3);
        end
    endtask

    task automatic audio_sweep();
        logic [31:0] r;
        int          hold;
        for (int seg = 0; seg < 12; seg++) begin
            @(posedge clk_rom);
            r = rand32();
            if (seg == 0) begin
                r = 32'h8000_7fff;          // Full scale on both rails
            end
            snd_left  <= snd_sample_t'(r[15:0]);
            snd_right <= snd_sample_t'(r[31:16]);
            hold = 40 + int'(rand32() % 32'd60);
            for (int c = 0; c < hold; c++) begin
                @(negedge clk_rom);
                check_value("snd_pwm_l", 32'(snd_pwm_l), 32'(exp_pwm_l));
                check_value("snd_pwm_r", 32'(snd_pwm_r), 32'(exp_pwm_r));
            end
        end
    endtask

    initial begin
        rng        = 32'd7;
        rst_n      = 1'b0;
        game_r     = '0;
        game_g     = '0;
        game_b     = '0;
        hs         = 1'b0;
        vs         = 1'b0;
        scan2x_r   = '0;
        scan2x_g   = '0;
        scan2x_b   = '0;
        scan2x_hs  = 1'b0;
        scan2x_vs  = 1'b0;
        vgactrl_en = 4'd0;
        snd_left   = '0;
        snd_right  = '0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_rom);
            check_value("ioctl_wr", 32'(ioctl_wr), 32'd0);
            check_value("sd_clk", 32'(sd_clk), 32'd0);
            check_value("sd_cs_n", 32'(sd_cs_n), 32'd1);
            check_value("downloading", 32'(downloading), 32'd1);
            check_value("snd_pwm_l", 32'(snd_pwm_l), 32'd0);
            check_value("snd_pwm_r", 32'(snd_pwm_r), 32'd0);
        end
        @(posedge clk_rom);
        rst_n <= 1'b1;
        fork
            watch_rom_load();
            begin
                video_sweep(1'b1);
                video_sweep(1'b0);
                audio_sweep();
            end
        join
        check_value("flash command count", 32'(cmd_count), 32'd1);
        $display("Error counts: %0d mismatches, %0d other failures, %0d flash model errors",
                 mismatches, problems, flash_errs);
        if (mismatches + problems + flash_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tb_spi_flash.sv
/*
 * SPI flash model
 * Decodes the mode-0 read command and serves pseudo-random bytes
 */
`timescale 1ns/10ps
`include "platform_cfg.svh"

module tb_spi_flash (
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output int   cmd_count,
    output int   err_count
);

    localparam int MEM_SIZE = 256;          // Window starting at ROM_BASE

    logic [7:0]  mem [0:MEM_SIZE-1];
    logic [31:0] cmd_sr;                    // Opcode and address bits
    logic [31:0] word;
    logic [23:0] start_addr = '0;
    logic [7:0]  out_sr;
    logic [7:0]  cur;
    logic        so = 1'b1;
    int          nbits = 0;                 // Rising edges since select
    int          cmds = 0;
    int          errs = 0;

    assign miso      = so;
    assign cmd_count = cmds;
    assign err_count = errs;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Outside the window the bus floats high
    function automatic logic [7:0] read_byte(input logic [23:0] addr);
        logic [23:0] offset;
        offset = addr - `ROM_BASE;
        if (offset < 24'(MEM_SIZE)) begin
            return mem[offset[7:0]];
        end
        return 8'hff;
    endfunction

    // Sequence value folded with the full flash address
    initial begin : fill
        logic [31:0] st;
        logic [23:0] a;
        st = 32'd7;
        for (int i = 0; i < MEM_SIZE; i++) begin
            st = xorshift32(st);
            a  = `ROM_BASE + 24'(i);
            mem[8'(i)] = st[7:0] ^ a[23:16] ^ a[15:8] ^ a[7:0];
        end
    end

    // Command bits in on rising SCK, counter cleared while deselected
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            nbits <= 0;
        end else begin
            cmd_sr <= {cmd_sr[30:0], mosi};
            nbits  <= nbits + 1;
            if (nbits == 31) begin
                word = {cmd_sr[30:0], mosi};
                cmds <= cmds + 1;
                start_addr <= word[23:0];
                if (word[31:24] != 8'h03) begin
                    $display("Flash model received read opcode %h instead of 03",
                             word[31:24]);
                    errs <= errs + 1;
                end
                if (word[23:0] != `ROM_BASE) begin
                    $display("Flash model received start address %h instead of %h",
                             word[23:0], `ROM_BASE);
                    errs <= errs + 1;
                end
            end
        end
    end

    // Data out on falling SCK, new byte every eighth edge
    always @(negedge sck) begin
        if (!cs_n && nbits >= 32) begin
            if (nbits % 8 == 0) begin
                cur = read_byte(start_addr + 24'((nbits - 32) / 8));
                so     <= cur[7];
                out_sr <= {cur[6:0], 1'b0};
            end else begin
                so     <= out_sr[7];
                out_sr <= {out_sr[6:0], 1'b0};
            end
        end
    end

endmodule

//--- video_out_mux.sv
/*
 * Video output mux
 * Native 15 kHz RGB with composite sync or scan-doubled VGA
 */
`timescale 1ns/10ps

module video_out_mux
    import platform_pkg::*;
(
    input  logic    scan2x_enb,
    input  color4_t game_r,
    input  color4_t game_g,
    input  color4_t game_b,
    input  logic    hs,
    input  logic    vs,
    input  color6_t scan2x_r,
    input  color6_t scan2x_g,
    input  color6_t scan2x_b,
    input  logic    scan2x_hs,
    input  logic    scan2x_vs,
    output color6_t video_r,
    output color6_t video_g,
    output color6_t video_b,
    output logic    video_hs,
    output logic    video_vs
);

    logic hsync_n;
    logic vsync_n;
    logic csync;

    // Core syncs are active high, the cable wants them low
    assign hsync_n = ~hs;
    assign vsync_n = ~vs;
    assign csync   = ~(hsync_n ^ vsync_n);

    // Native colours gain two zero LSBs
    assign video_r = scan2x_enb ? {game_r, 2'b00} : scan2x_r;
    assign video_g = scan2x_enb ? {game_g, 2'b00} : scan2x_g;
    assign video_b = scan2x_enb ? {game_b, 2'b00} : scan2x_b;

    // An RGB cable takes csync on HS and a high VS to select RGB mode
    assign video_hs = scan2x_enb ? csync : scan2x_hs;
    assign video_vs = scan2x_enb ? 1'b1  : scan2x_vs;

endmodule
